// File: verilog.f
+incdir+common
common/spi_frame_pkg.sv
common/reg_map_pkg.sv
rtl/spi_pin_sync.sv
spi_slave/spi_shift_in.sv
spi_slave/spi_shift_out.sv
spi_slave/spi_frame_ctrl.sv
rtl/reg_bank.sv
rtl/spi_reg_top.sv
dv/spi_reg_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the spi register testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module spi_reg_tb \
    -f verilog.f \
    --Mdir obj_dir \
    -o spi_reg_sim

# the simulator exits nonzero on failure, the log decides
./obj_dir/spi_reg_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: dv/spi_reg_tb.sv
`default_nettype none

`include "spi_link_defines.svh"

// spi mode 0 master driving the register slave
// register model kept alongside, checked after every frame
module spi_reg_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    // clk cycles per sclk half period
    localparam int HALF         = 10;
    localparam int IDLE         = 12;
    localparam int NUM_FRAMES   = 200;
    // every full frame may be preceded by one aborted frame
    localparam int MAX_FRAMES   = 2 * NUM_FRAMES;
    localparam int TIMEOUT      = MAX_FRAMES * `SPI_FRAME_BITS * (2 * HALF) * 2 * CLK_PERIOD
                                  + 1000 * CLK_PERIOD;

    logic clk;
    logic rst;
    logic sclk;
    logic cs_n;
    logic mosi;
    logic miso;
    logic frame_done;
    spi_frame_pkg::data_t reg0_q;
    spi_frame_pkg::data_t reg1_q;
    spi_frame_pkg::data_t reg2_q;
    spi_frame_pkg::data_t reg3_q;

    // expected register contents
    spi_frame_pkg::data_t model_regs [`SPI_NUM_REGS];

    integer seed;
    int     done_count;
    int     num_writes;
    int     num_reads;
    int     num_aborts;

    spi_reg_top DUT (
        .clk        (clk),
        .rst        (rst),
        .sclk       (sclk),
        .cs_n       (cs_n),
        .mosi       (mosi),
        .miso       (miso),
        .frame_done (frame_done),
        .reg0_q     (reg0_q),
        .reg1_q     (reg1_q),
        .reg2_q     (reg2_q),
        .reg3_q     (reg3_q)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // count of frame_done pulses
    // taken on the falling edge of clk
    initial done_count = 0;
    always @(negedge clk) begin
        if (frame_done) begin
            done_count = done_count + 1;
        end
    end

    // **************************************************
    // failure reporting and compare tasks
    // **************************************************

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_byte(input string what, input spi_frame_pkg::data_t got,
                              input spi_frame_pkg::data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    // all four outputs against the model
    task automatic check_regs();
        check_byte("reg0_q", reg0_q, model_regs[reg_map_pkg::REG0]);
        check_byte("reg1_q", reg1_q, model_regs[reg_map_pkg::REG1]);
        check_byte("reg2_q", reg2_q, model_regs[reg_map_pkg::REG2]);
        check_byte("reg3_q", reg3_q, model_regs[reg_map_pkg::REG3]);
    endtask

    // done pulse is due 4 clk after the 16th pin rise
    task automatic wait_frame_done();
        int n;
        n = 0;
        while (frame_done !== 1'b1 && n < 2 * HALF) begin
            @(negedge clk);
            n++;
        end
        if (frame_done !== 1'b1) begin
            abort_run("frame_done did not pulse after the last sclk rise of a full frame");
        end
    endtask

    // **************************************************
    // spi master
    // **************************************************

    // shifts nbits of {cmd, data}, then raises cs_n
    // miso is captured on the master's rises of byte two
    task automatic shift_frame(input spi_frame_pkg::data_t cmd, input spi_frame_pkg::data_t data,
                               input int nbits, output spi_frame_pkg::data_t miso_byte);
        logic [`SPI_FRAME_BITS-1:0] frame;
        frame = {cmd, data};
        miso_byte = '0;
        @(posedge clk);
        cs_n <= 1'b0;
        mosi <= frame[`SPI_FRAME_BITS-1];
        for (int i = 0; i < nbits; i++) begin
            repeat (HALF) @(posedge clk);
            sclk <= 1'b1;
            // miso only moves 4 clk after a fall, so it is steady here
            @(negedge clk);
            if (i >= `SPI_DATA_W) begin
                miso_byte = {miso_byte[`SPI_DATA_W-2:0], miso};
            end
            if (i == `SPI_FRAME_BITS - 1) begin
                wait_frame_done();
            end
            repeat (HALF) @(posedge clk);
            sclk <= 1'b0;
            if (i < `SPI_FRAME_BITS - 1) begin
                mosi <= frame[`SPI_FRAME_BITS-2-i];
            end
        end
        repeat (HALF) @(posedge clk);
        cs_n <= 1'b1;
        mosi <= 1'b0;
        repeat (IDLE) @(posedge clk);
        // hand back on a falling edge so the caller sees settled outputs
        @(negedge clk);
    endtask

    // one complete frame with random flag, address and data
    task automatic run_full_frame();
        logic [31:0]            rnd;
        logic                   wr;
        reg_map_pkg::reg_addr_t addr;
        spi_frame_pkg::data_t   data;
        spi_frame_pkg::data_t   exp_miso;
        spi_frame_pkg::data_t   got_miso;
        int                     done_before;
        rnd = $random(seed);
        wr = rnd[0];
        addr = reg_map_pkg::reg_addr_t'(rnd[2:1]);
        data = rnd[15:8];
        // read data is the value before this frame's write
        exp_miso = model_regs[addr];
        done_before = done_count;
        // ignored command bits carry random fill
        shift_frame({wr, rnd[28:24], rnd[2:1]}, data, `SPI_FRAME_BITS, got_miso);
        check_byte("miso read-back", got_miso, exp_miso);
        if (done_count != done_before + 1) begin
            abort_run("a full frame did not give exactly one frame_done pulse");
        end
        if (wr) begin
            model_regs[addr] = data;
            num_writes++;
        end else begin
            num_reads++;
        end
        check_regs();
    endtask

    // cs_n rises after 1 to 15 bits
    // no register may change and no frame_done may pulse
    task automatic run_aborted_frame();
        logic [31:0]          rnd;
        int                   nbits;
        int                   done_before;
        spi_frame_pkg::data_t got_miso;
        rnd = $random(seed);
        nbits = int'(rnd[19:16]) % 15 + 1;
        done_before = done_count;
        shift_frame(rnd[7:0], rnd[15:8], nbits, got_miso);
        if (done_count != done_before) begin
            abort_run($sformatf("frame aborted after %0d bits still gave frame_done", nbits));
        end
        num_aborts++;
        check_regs();
    endtask

    // **************************************************
    // main sequence
    // **************************************************

    initial begin
        logic [31:0] rnd;
        rst = 1'b1;
        sclk = 1'b0;
        cs_n = 1'b1;
        mosi = 1'b0;
        seed = 32'hb252_dc18;
        num_writes = 0;
        num_reads = 0;
        num_aborts = 0;
        for (int i = 0; i < `SPI_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_regs();
        check_bit("miso after reset", miso, 1'b0);
        check_bit("frame_done after reset", frame_done, 1'b0);
        repeat (IDLE) @(posedge clk);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            rnd = $random(seed);
            // roughly one frame in four is preceded by an abort
            if (rnd[23:22] == 2'b00) begin
                run_aborted_frame();
            end
            run_full_frame();
        end
        $display("frames: %0d writes, %0d reads, %0d aborted", num_writes, num_reads, num_aborts);
        // every kind of frame has to have been exercised
        if (num_writes == 0 || num_reads == 0 || num_aborts == 0) begin
            abort_run("random stimulus did not cover write, read and aborted frames");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        abort_run($sformatf("simulation timed out at %0t before all frames were done", $time));
    end

endmodule

`default_nettype wire

// File: rtl/spi_reg_top.sv
`default_nettype none

// spi mode 0 slave with a four register bank behind it
// pins are asynchronous to clk
module spi_reg_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sclk,
    input  logic                 cs_n,
    input  logic                 mosi,
    output logic                 miso,
    output logic                 frame_done,
    output spi_frame_pkg::data_t reg0_q,
    output spi_frame_pkg::data_t reg1_q,
    output spi_frame_pkg::data_t reg2_q,
    output spi_frame_pkg::data_t reg3_q
);

    // synchronized pin view
    logic sclk_rise;
    logic sclk_fall;
    logic cs_active;
    logic mosi_s;

    // frame events
    logic load_out;
    logic wr_en;

    // byte paths
    spi_frame_pkg::data_t   rx_byte;
    spi_frame_pkg::data_t   rd_data;
    reg_map_pkg::reg_addr_t addr;

    // **************************************************
    // pin front end
    // **************************************************

    spi_pin_sync u_pin_sync (
        .clk       (clk),
        .rst       (rst),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall),
        .cs_active (cs_active),
        .mosi_s    (mosi_s)
    );

    // **************************************************
    // slave datapath and control
    // **************************************************

    spi_shift_in u_shift_in (
        .clk       (clk),
        .rst       (rst),
        .sclk_rise (sclk_rise),
        .mosi_s    (mosi_s),
        .cs_active (cs_active),
        .rx_byte   (rx_byte)
    );

    spi_frame_ctrl u_frame_ctrl (
        .clk        (clk),
        .rst        (rst),
        .sclk_rise  (sclk_rise),
        .cs_active  (cs_active),
        .rx_byte    (rx_byte),
        .load_out   (load_out),
        .wr_en      (wr_en),
        .frame_done (frame_done),
        .addr       (addr)
    );

    // read data is the register value before any write of this frame
    spi_shift_out u_shift_out (
        .clk       (clk),
        .rst       (rst),
        .sclk_fall (sclk_fall),
        .load_out  (load_out),
        .load_byte (rd_data),
        .miso      (miso)
    );

    // one address serves both the read mux and the write decoder
    reg_bank u_reg_bank (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (addr),
        .wr_data (rx_byte),
        .rd_addr (addr),
        .rd_data (rd_data),
        .reg0_q  (reg0_q),
        .reg1_q  (reg1_q),
        .reg2_q  (reg2_q),
        .reg3_q  (reg3_q)
    );

endmodule

`default_nettype wire

// File: rtl/reg_bank.sv
`default_nettype none

`include "spi_link_defines.svh"

// four byte registers written through a one-hot select
// all values visible on the outputs at all times
module reg_bank (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_en,
    input  reg_map_pkg::reg_addr_t wr_addr,
    input  spi_frame_pkg::data_t   wr_data,
    input  reg_map_pkg::reg_addr_t rd_addr,
    output spi_frame_pkg::data_t   rd_data,
    output spi_frame_pkg::data_t   reg0_q,
    output spi_frame_pkg::data_t   reg1_q,
    output spi_frame_pkg::data_t   reg2_q,
    output spi_frame_pkg::data_t   reg3_q
);

    // write select, at most one bit high
    reg_map_pkg::reg_sel_t wr_sel;

    // register storage
    spi_frame_pkg::data_t regs [`SPI_NUM_REGS];

    // **************************************************
    // 2 to 4 write decoder
    // **************************************************

    always_comb begin
        wr_sel = '0;
        if (wr_en) begin
            case (wr_addr)
                reg_map_pkg::REG0: wr_sel = 4'b0001;
                reg_map_pkg::REG1: wr_sel = 4'b0010;
                reg_map_pkg::REG2: wr_sel = 4'b0100;
                reg_map_pkg::REG3: wr_sel = 4'b1000;
                default:           wr_sel = '0;
            endcase
        end
    end

    // registers load on the clk edge that ends the wr_en cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `SPI_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `SPI_NUM_REGS; i++) begin
                if (wr_sel[i]) begin
                    regs[i] <= wr_data;
                end
            end
        end
    end

    // read mux feeds the miso shifter
    assign rd_data = regs[rd_addr];

    assign reg0_q = regs[0];
    assign reg1_q = regs[1];
    assign reg2_q = regs[2];
    assign reg3_q = regs[3];

endmodule

`default_nettype wire

// File: spi_slave/spi_frame_ctrl.sv
`default_nettype none

`include "spi_link_defines.svh"

// counts the bits of a frame and issues the frame events
// load at the end of the command byte
// write and done at the end of the data byte
module spi_frame_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sclk_rise,
    input  logic                  cs_active,
    input  spi_frame_pkg::data_t  rx_byte,
    output logic                  load_out,
    output logic                  wr_en,
    output logic                  frame_done,
    output reg_map_pkg::reg_addr_t addr
);

    // rises seen in this frame
    spi_frame_pkg::bit_cnt_t bit_cnt;

    // command byte of the current or last frame
    spi_frame_pkg::cmd_t cmd_q;

    // rise that belongs to an active frame
    logic rise_ok;

    // this rise completes the command byte
    logic at_cmd;

    // this rise completes the whole frame
    logic at_end;

    assign rise_ok = sclk_rise & cs_active;

    // compare against the count before this rise is added
    assign at_cmd = rise_ok &&
        (bit_cnt == spi_frame_pkg::bit_cnt_t'(`SPI_DATA_W - 1));
    assign at_end = rise_ok &&
        (bit_cnt == spi_frame_pkg::bit_cnt_t'(`SPI_FRAME_BITS - 1));

    // **************************************************
    // bit counter
    // **************************************************

    // stops at the frame length
    // extra rises before cs_n goes high are ignored
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (!cs_active) begin
            // an early cs_n rise lands here and drops the frame
            bit_cnt <= '0;
        end else if (sclk_rise &&
                     bit_cnt != spi_frame_pkg::bit_cnt_t'(`SPI_FRAME_BITS)) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // command latch
    // rx_byte already carries the 8th bit in this cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_q <= '0;
        end else if (at_cmd) begin
            cmd_q <= spi_frame_pkg::cmd_t'(rx_byte);
        end
    end

    // **************************************************
    // event pulses
    // **************************************************

    // each is high for one clk, one cycle after its rise
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_out   <= 1'b0;
            wr_en      <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            load_out   <= at_cmd;
            frame_done <= at_end;
            // only write commands touch the register bank
            wr_en      <= at_end & cmd_q.wr;
        end
    end

    // address stays put until the next command byte
    // drives the read mux for miso and the write decoder
    assign addr = reg_map_pkg::reg_addr_t'(cmd_q.addr);

endmodule

`default_nettype wire

// File: spi_slave/spi_shift_out.sv
`default_nettype none

`include "spi_link_defines.svh"

// parallel in, serial out
// drives miso msb first for the data byte of a frame
module spi_shift_out (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sclk_fall,
    input  logic                 load_out,
    input  spi_frame_pkg::data_t load_byte,
    output logic                 miso
);

    // bits still to go out
    // current bit in the msb
    spi_frame_pkg::data_t shift_q;

    // set by a load
    // keeps the msb on the line across the next sclk fall
    logic hold_msb;

    // **************************************************
    // mode 0 timing
    // **************************************************

    // the load happens right after the 8th rise
    // the 8th fall follows before the master samples bit 8
    // so that fall must not move the msb away
    // falls 9 to 15 then present bits 6 to 0
    // and the 16th fall leaves only zero fill behind

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_msb <= 1'b0;
        end else if (load_out) begin
            hold_msb <= 1'b1;
        end else if (sclk_fall) begin
            hold_msb <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_q <= '0;
        end else if (load_out) begin
            shift_q <= load_byte;
        end else if (sclk_fall && !hold_msb) begin
            // zero fill so the line settles low after the byte
            shift_q <= {shift_q[`SPI_DATA_W-2:0], 1'b0};
        end
    end

    // miso follows the register directly
    // one clk after the load or the fall pulse
    assign miso = shift_q[`SPI_DATA_W-1];

endmodule

`default_nettype wire

// File: spi_slave/spi_shift_in.sv
`default_nettype none

`include "spi_link_defines.svh"

// serial in, parallel out
// mosi is sampled on every sclk rise of an active frame
module spi_shift_in (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sclk_rise,
    input  logic                 mosi_s,
    input  logic                 cs_active,
    output spi_frame_pkg::data_t rx_byte
);

    // bits shifted so far
    // newest bit sits in the lsb
    spi_frame_pkg::data_t shift_q;

    // the byte as it will be once this rise is taken
    spi_frame_pkg::data_t shift_d;

    // rise that belongs to the current frame
    logic shift_en;

    assign shift_en = sclk_rise & cs_active;

    // msb first on the wire
    // so older bits move up one place
    assign shift_d = {shift_q[`SPI_DATA_W-2:0], mosi_s};

    // **************************************************
    // shift register
    // **************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_q <= '0;
        end else if (!cs_active) begin
            // start every frame from an empty byte
            shift_q <= '0;
        end else if (shift_en) begin
            shift_q <= shift_d;
        end
    end

    // frame control latches on the very rise that completes a byte
    // so pass the incoming bit straight through in that cycle
    // otherwise the register holds the last full byte
    // which is what the write in the next cycle picks up
    always_comb begin
        if (shift_en) begin
            rx_byte = shift_d;
        end else begin
            rx_byte = shift_q;
        end
    end

endmodule

`default_nettype wire

// File: rtl/spi_pin_sync.sv
`default_nettype none

`include "spi_link_defines.svh"

// brings sclk, cs_n and mosi into the clk domain
// sclk edges come out as single-clk pulses
module spi_pin_sync (
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic sclk_rise,
    output logic sclk_fall,
    output logic cs_active,
    output logic mosi_s
);

    // **************************************************
    // synchronizer chains
    // **************************************************

    // bit 0 takes the raw pin, top bit is the safe copy
    logic [`SPI_SYNC_STAGES-1:0] sclk_sync;
    logic [`SPI_SYNC_STAGES-1:0] cs_n_sync;
    logic [`SPI_SYNC_STAGES-1:0] mosi_sync;

    // synchronized sclk and its value one clk earlier
    logic sclk_s;
    logic sclk_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk_sync <= '0;
            // cs_n idles high so reset it inactive
            cs_n_sync <= '1;
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[`SPI_SYNC_STAGES-2:0], sclk};
            cs_n_sync <= {cs_n_sync[`SPI_SYNC_STAGES-2:0], cs_n};
            mosi_sync <= {mosi_sync[`SPI_SYNC_STAGES-2:0], mosi};
        end
    end

    assign sclk_s = sclk_sync[`SPI_SYNC_STAGES-1];

    // **************************************************
    // sclk edge detect
    // **************************************************

    // pulses are registered
    // so a pin edge shows up 3 clk later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk_last <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
        end else begin
            sclk_last <= sclk_s;
            sclk_rise <= sclk_s & ~sclk_last;
            sclk_fall <= ~sclk_s & sclk_last;
        end
    end

    // chip select is active low on the pin
    assign cs_active = ~cs_n_sync[`SPI_SYNC_STAGES-1];

    // data level, sampled by the shifter on sclk_rise
    assign mosi_s = mosi_sync[`SPI_SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: common/reg_map_pkg.sv
`default_nettype none

`include "spi_link_defines.svh"

// types that describe the register map behind the spi slave
package reg_map_pkg;

    // register address as carried in the command byte
    typedef enum logic [1:0] {
        REG0 = 2'd0,
        REG1 = 2'd1,
        REG2 = 2'd2,
        REG3 = 2'd3
    } reg_addr_t;

    // one-hot write select
    // one bit per register
    typedef logic [`SPI_NUM_REGS-1:0] reg_sel_t;

endpackage

`default_nettype wire

// File: common/spi_frame_pkg.sv
`default_nettype none

`include "spi_link_defines.svh"

// types that describe the serial frame on the wire
package spi_frame_pkg;

    // one byte as shifted in or out
    typedef logic [`SPI_DATA_W-1:0] data_t;

    // position inside a frame
    // needs to hold 0 up to the full frame length
    typedef logic [$clog2(`SPI_FRAME_BITS + 1)-1:0] bit_cnt_t;

    // **************************************************
    // command byte layout, first byte of every frame
    // **************************************************

    // msb first on the wire so wr is the first bit seen
    typedef struct packed {
        // 1 commits the data byte at end of frame
        logic                  wr;
        // bits 6..2 are don't care
        logic [`SPI_DATA_W-4:0] rsvd;
        // register address
        logic [1:0]            addr;
    } cmd_t;

endpackage

`default_nettype wire

// File: common/spi_link_defines.svh
`ifndef SPI_LINK_DEFINES_SVH
`define SPI_LINK_DEFINES_SVH

// **************************************************
// spi link sizing
// **************************************************

// width of one spi byte and of each register
`define SPI_DATA_W 8

// sclk rises per frame
// command byte then data byte
`define SPI_FRAME_BITS 16

// flops per pin in the input synchronizer
`define SPI_SYNC_STAGES 2

// registers reachable through the 2-bit address field
`define SPI_NUM_REGS 4

`endif
